// ==== tb.f ====
+incdir+.
cpu_pkg.sv
cpu_if.sv
fetch_decode.sv
reg_file.sv
alu.sv
bus_ctrl.sv
cpu.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f tb.f --top-module tb_cpu -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int DATA_BASE = 'h80;
    localparam int SEED      = 61354;

    logic                   clock;
    logic                   arst_n;
    logic [`CPU_DATA_W-1:0] data;
    logic [`CPU_DATA_W-1:0] datao;
    logic [`CPU_DATA_W-1:0] address;
    logic                   rw;

    logic [`CPU_DATA_W-1:0] image [MEM_WORDS];
    logic [`CPU_DATA_W-1:0] mem [MEM_WORDS];
    int                     prog_len;
    logic [`CPU_DATA_W-1:0] halt_pc;
    int                     errors;

    // reference model, one instruction per three cycles
    cpu_state_e             phase;
    logic [`CPU_DATA_W-1:0] m_pc;
    logic [`CPU_DATA_W-1:0] m_regs [`CPU_NREGS];
    logic                   m_flags [`CPU_NREGS];
    logic [`CPU_DATA_W-1:0] m_mem [MEM_WORDS];
    logic [`CPU_DATA_W-1:0] m_ir;
    logic [5:0]             m_opc;
    logic [2:0]             m_a;
    logic [2:0]             m_b;
    logic [2:0]             m_d;
    logic [15:0]            m_imm;
    logic [`CPU_DATA_W-1:0] va;
    logic [`CPU_DATA_W-1:0] vb;
    logic [`CPU_DATA_W:0]   wide;
    logic [`CPU_DATA_W-1:0] p_result;
    logic                   p_flag;
    logic                   p_we;
    logic                   p_store;
    logic                   p_access;
    logic                   p_branch;
    logic [`CPU_DATA_W-1:0] exp_address;
    logic                   exp_rw;

    cpu i_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // memory answers in the same cycle
    assign data = mem[address[7:0]];

    always @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= image[i];
        end
        else if (!rw)
        begin
            mem[address[7:0]] <= datao;
        end
    end

    assign m_ir  = m_mem[m_pc[7:0]];
    assign m_opc = m_ir[OPC_LSB +: 6];
    assign m_a   = m_ir[SRCA_LSB +: 3];
    assign m_b   = m_ir[SRCB_LSB +: 3];
    assign m_d   = m_ir[DST_LSB +: 3];
    assign m_imm = m_ir[IMM_LSB +: 16];
    assign va    = m_regs[m_a];
    assign vb    = m_regs[m_b];

    always_comb
    begin
        wide     = '0;
        p_result = '0;
        p_flag   = 1'b0;
        p_we     = 1'b0;
        p_store  = 1'b0;
        p_access = 1'b0;
        p_branch = 1'b0;
        case (m_opc)
            OP_ADD, OP_SUB:
            begin
                if (m_opc == OP_ADD)
                    wide = {1'b0, va} + {1'b0, vb};
                else
                    wide = {1'b0, va} - {1'b0, vb};
                p_result = wide[`CPU_DATA_W-1:0];
                p_flag   = wide[`CPU_DATA_W];
                p_we     = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR:
            begin
                if (m_opc == OP_AND)
                    p_result = va & vb;
                else if (m_opc == OP_OR)
                    p_result = va | vb;
                else
                    p_result = va ^ vb;
                p_flag = (p_result == 32'd0);
                p_we   = 1'b1;
            end
            OP_LDI:
            begin
                p_result = m_ir[HL_BIT] ? {m_imm, va[15:0]} : {va[31:16], m_imm};
                p_we     = 1'b1;
            end
            OP_CMPEQ, OP_CMPLT:
            begin
                p_flag   = (m_opc == OP_CMPEQ) ? (va == vb) : (va < vb);
                p_result = {31'd0, p_flag};
                p_we     = 1'b1;
            end
            OP_LOAD:
            begin
                p_result = m_mem[vb[7:0]];
                p_flag   = (p_result == 32'd0);
                p_we     = 1'b1;
                p_access = 1'b1;
            end
            OP_STORE:
            begin
                p_store  = 1'b1;
                p_access = 1'b1;
            end
            OP_BRF:  p_branch = m_flags[m_a];
            OP_JMP:  p_branch = 1'b1;
            default: ;
        endcase
    end

    always_comb
    begin
        exp_address = ((phase == ST_EXECUTE) && p_access) ? vb : m_pc;
        exp_rw      = !((phase == ST_EXECUTE) && p_store);
    end

    always @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase <= ST_FETCH;
            m_pc  <= `CPU_RESET_PC;
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                m_regs[i]  <= '0;
                m_flags[i] <= 1'b0;
            end
            for (int i = 0; i < MEM_WORDS; i++)
                m_mem[i] <= image[i];
        end
        else
        begin
            case (phase)
                ST_FETCH:   phase <= ST_EXECUTE;
                ST_EXECUTE: phase <= ST_UPDATE;
                default:    phase <= ST_FETCH;
            endcase
            if (phase == ST_EXECUTE)
            begin
                if (p_we)
                begin
                    m_regs[m_d]  <= p_result;
                    m_flags[m_d] <= p_flag;
                end
                if (p_store)
                    m_mem[vb[7:0]] <= va;
            end
            if (phase == ST_UPDATE)
                m_pc <= p_branch ? {16'd0, m_imm} : m_pc + 32'd1;
        end
    end

    function automatic void report_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
        errors++;
        $display("ERROR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    endfunction

    function automatic logic [31:0] encode(logic [5:0] op, int a, int b, int d, logic hl,
                                           logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        w[OPC_LSB +: 6]  = op;
        w[SRCA_LSB +: 3] = 3'(a);
        w[SRCB_LSB +: 3] = 3'(b);
        w[DST_LSB +: 3]  = 3'(d);
        w[HL_BIT]        = hl;
        w[IMM_LSB +: 16] = imm;
        return w;
    endfunction

    task automatic put_word(input logic [31:0] w);
        image[prog_len] = w;
        prog_len++;
    endtask

    // op into r3, store r3 to its slot, then branch on r3's flag over a store of r1
    task automatic op_group(input logic [5:0] op, input int a, input int b, input logic hl,
                            input int slot);
        put_word(encode(op, a, b, 3, hl, 16'($urandom())));
        put_word(encode(OP_LDI, 0, 0, 5, 1'b0, 16'(DATA_BASE + slot)));
        put_word(encode(OP_STORE, 3, 5, 0, 1'b0, 16'd0));
        put_word(encode(OP_BRF, 3, 0, 0, 1'b0, 16'(prog_len + 2)));
        put_word(encode(OP_STORE, 1, 5, 0, 1'b0, 16'd0));
    endtask

    task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++)
            image[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
        prog_len = 0;
        put_word(encode(OP_LDI, 0, 0, 1, 1'b0, 16'($urandom())));
        put_word(encode(OP_LDI, 1, 0, 1, 1'b1, 16'($urandom())));
        put_word(encode(OP_LDI, 0, 0, 2, 1'b0, 16'($urandom())));
        put_word(encode(OP_LDI, 2, 0, 2, 1'b1, 16'($urandom())));
        op_group(OP_ADD, 1, 2, 1'b0, 0);
        op_group(OP_SUB, 1, 2, 1'b0, 1);
        op_group(OP_AND, 1, 2, 1'b0, 2);
        op_group(OP_OR, 1, 2, 1'b0, 3);
        op_group(OP_XOR, 1, 2, 1'b0, 4);
        op_group(OP_XOR, 1, 1, 1'b0, 5);
        op_group(OP_LDI, 1, 0, 1'b1, 6);
        op_group(OP_LDI, 2, 0, 1'b0, 7);
        op_group(OP_CMPEQ, 1, 1, 1'b0, 8);
        op_group(OP_CMPEQ, 1, 2, 1'b0, 9);
        op_group(OP_CMPLT, 1, 2, 1'b0, 10);
        op_group(OP_CMPLT, 2, 1, 1'b0, 11);
        // undefined codes after r3 holds 1 with its flag set
        put_word(encode(OP_CMPEQ, 1, 1, 3, 1'b0, 16'd0));
        op_group(6'd13, 1, 2, 1'b0, 12);
        put_word(encode(OP_CMPEQ, 1, 1, 3, 1'b0, 16'd0));
        op_group(6'h3f, 2, 1, 1'b1, 13);
        // load back a stored word and a fill word, copy both out
        put_word(encode(OP_LDI, 0, 0, 6, 1'b0, 16'(DATA_BASE + 16)));
        put_word(encode(OP_LDI, 0, 0, 5, 1'b0, 16'(DATA_BASE)));
        put_word(encode(OP_LOAD, 0, 5, 4, 1'b0, 16'd0));
        put_word(encode(OP_STORE, 4, 6, 0, 1'b0, 16'd0));
        put_word(encode(OP_LDI, 0, 0, 5, 1'b0, 16'h00c7));
        put_word(encode(OP_LOAD, 0, 5, 4, 1'b0, 16'd0));
        put_word(encode(OP_STORE, 4, 6, 0, 1'b0, 16'd0));
        put_word(encode(OP_JMP, 0, 0, 0, 1'b0, 16'(prog_len + 2)));
        put_word(encode(OP_STORE, 2, 6, 0, 1'b0, 16'd0));
        halt_pc = 32'(prog_len);
        put_word(encode(OP_JMP, 0, 0, 0, 1'b0, 16'(prog_len)));
    endtask

    a_address: assert property (@(posedge clock) disable iff (!arst_n)
        address == exp_address)
        else report_mismatch("address", $sampled(exp_address), $sampled(address));

    a_rw: assert property (@(posedge clock) disable iff (!arst_n)
        rw == exp_rw)
        else report_mismatch("rw", 32'($sampled(exp_rw)), 32'($sampled(rw)));

    a_datao: assert property (@(posedge clock) disable iff (!arst_n)
        !exp_rw |-> datao == m_regs[m_a])
        else report_mismatch("datao", $sampled(m_regs[m_a]), $sampled(datao));

    // a write is one cycle long and sits in the middle of an instruction
    a_write_pulse: assert property (@(posedge clock) disable iff (!arst_n)
        !rw |-> (phase == ST_EXECUTE) ##1 rw)
        else
        begin
            errors++;
            $display("memory write at %0t was not a single cycle in EXECUTE", $time);
        end

    initial
    begin
        int cycles;
        int halts;
        int limit;
        bit done;
        arst_n = 1'b0;
        errors = 0;
        cycles = 0;
        halts  = 0;
        done   = 1'b0;
        void'($urandom(SEED));
        build_program();
        limit = prog_len * 3 + 50;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        // two fetches of the final self-jump mean the program is done
        while (!done && cycles < limit)
        begin
            @(negedge clock);
            cycles++;
            if (phase == ST_FETCH && address == halt_pc)
                halts++;
            done = (halts >= 2);
        end
        if (!done)
        begin
            errors++;
            $display("timeout: no self-jump at %h after %0d cycles", halt_pc, limit);
        end
        $display("run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic [`CPU_DATA_W-1:0] data,
    output logic [`CPU_DATA_W-1:0] datao,
    output logic [`CPU_DATA_W-1:0] address,
    output logic                   rw
);

    decode_if  dec ();
    operand_if opnd ();
    result_if  res ();

    // sequencer and instruction register
    fetch_decode i_fetch_decode (
        .clock  (clock),
        .arst_n (arst_n),
        .data   (data),
        .dec    (dec)
    );

    reg_file i_reg_file (
        .clock  (clock),
        .arst_n (arst_n),
        .dec    (dec),
        .opnd   (opnd),
        .res    (res)
    );

    // load data enters through here
    alu i_alu (
        .data   (data),
        .dec    (dec),
        .opnd   (opnd),
        .res    (res)
    );

    bus_ctrl i_bus_ctrl (
        .clock   (clock),
        .arst_n  (arst_n),
        .dec     (dec),
        .opnd    (opnd),
        .res     (res),
        .address (address),
        .datao   (datao),
        .rw      (rw)
    );

endmodule

// ==== bus_ctrl.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module bus_ctrl (
    input  logic                   clock,
    input  logic                   arst_n,
    decode_if.sink                 dec,
    operand_if.sink                opnd,
    result_if.sink                 res,
    output logic [`CPU_DATA_W-1:0] address,
    output logic [`CPU_DATA_W-1:0] datao,
    output logic                   rw
);

    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] target;

    // branch target is the zero extended immediate
    assign target = {{(`CPU_DATA_W/2){1'b0}}, dec.imm};

    // pc moves once per instruction at the end of UPDATE
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= `CPU_RESET_PC;
        end
        else if (dec.in_update)
        begin
            if (res.take_branch)
                pc <= target;
            else
                pc <= pc + 1'b1;
        end
    end

    // data accesses borrow the bus only during EXECUTE
    assign address = (dec.in_execute && res.access) ? opnd.b_val : pc;
    assign rw      = !(dec.in_execute && res.store);
    assign datao   = opnd.a_val;

    // a write always targets the address taken from source B
    a_write_addr: assert property (
        @(posedge clock) disable iff (!arst_n)
        !rw |-> (address == opnd.b_val)
    ) else $error("write address is not source B");

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module alu (
    input  logic [`CPU_DATA_W-1:0] data,
    decode_if.sink                 dec,
    operand_if.sink                opnd,
    result_if.source               res
);
    import cpu_pkg::*;

    localparam int HALF_W = `CPU_DATA_W / 2;

    logic [`CPU_DATA_W:0] sum;
    logic [`CPU_DATA_W:0] diff;

    // extra bit holds carry out and borrow
    assign sum  = {1'b0, opnd.a_val} + {1'b0, opnd.b_val};
    assign diff = {1'b0, opnd.a_val} - {1'b0, opnd.b_val};

    always_comb
    begin
        res.result      = '0;
        res.flag_out    = 1'b0;
        res.write_en    = 1'b0;
        res.store       = 1'b0;
        res.access      = 1'b0;
        res.take_branch = 1'b0;

        case (dec.op)
            OP_ADD:
            begin
                res.result   = sum[`CPU_DATA_W-1:0];
                res.flag_out = sum[`CPU_DATA_W];
                res.write_en = 1'b1;
            end
            OP_SUB:
            begin
                res.result   = diff[`CPU_DATA_W-1:0];
                res.flag_out = diff[`CPU_DATA_W];
                res.write_en = 1'b1;
            end
            OP_AND:
            begin
                res.result   = opnd.a_val & opnd.b_val;
                res.flag_out = (res.result == '0);
                res.write_en = 1'b1;
            end
            OP_OR:
            begin
                res.result   = opnd.a_val | opnd.b_val;
                res.flag_out = (res.result == '0);
                res.write_en = 1'b1;
            end
            OP_XOR:
            begin
                res.result   = opnd.a_val ^ opnd.b_val;
                res.flag_out = (res.result == '0);
                res.write_en = 1'b1;
            end
            OP_LDI:
            begin
                // the other half comes from source A
                if (dec.high_low)
                    res.result = {dec.imm, opnd.a_val[HALF_W-1:0]};
                else
                    res.result = {opnd.a_val[`CPU_DATA_W-1:HALF_W], dec.imm};
                res.write_en = 1'b1;
            end
            OP_CMPEQ:
            begin
                res.flag_out = (opnd.a_val == opnd.b_val);
                res.result   = {{(`CPU_DATA_W-1){1'b0}}, res.flag_out};
                res.write_en = 1'b1;
            end
            OP_CMPLT:
            begin
                res.flag_out = (opnd.a_val < opnd.b_val);
                res.result   = {{(`CPU_DATA_W-1){1'b0}}, res.flag_out};
                res.write_en = 1'b1;
            end
            OP_LOAD:
            begin
                res.result   = data;
                res.flag_out = (data == '0);
                res.write_en = 1'b1;
                res.access   = 1'b1;
            end
            OP_STORE:
            begin
                res.store  = 1'b1;
                res.access = 1'b1;
            end
            OP_BRF:   res.take_branch = opnd.a_flag;
            OP_JMP:   res.take_branch = 1'b1;
            default:  ;
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module reg_file (
    input  logic      clock,
    input  logic      arst_n,
    decode_if.sink    dec,
    operand_if.source opnd,
    result_if.sink    res
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0]  flags;
    logic                   wr;

    // results are committed on the edge that ends EXECUTE
    assign wr = dec.in_execute && res.write_en;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr)
        begin
            regs[dec.dst] <= res.result;
        end
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            flags <= '0;
        end
        else if (wr)
        begin
            flags[dec.dst] <= res.flag_out;
        end
    end

    // two combinational read ports
    assign opnd.a_val  = regs[dec.src_a];
    assign opnd.b_val  = regs[dec.src_b];
    assign opnd.a_flag = flags[dec.src_a];
    assign opnd.b_flag = flags[dec.src_b];

    // a write may only land while the ALU result is valid
    a_write_window: assert property (
        @(posedge clock) disable iff (!arst_n)
        wr |-> $past(dec.in_fetch)
    ) else $error("register write outside EXECUTE");

endmodule

// ==== fetch_decode.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_decode (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic [`CPU_DATA_W-1:0] data,
    decode_if.source               dec
);
    import cpu_pkg::*;

    cpu_state_e                 state;
    cpu_state_e                 state_nxt;
    logic [`CPU_DATA_W-1:0]     ir;
    logic [$bits(alu_op_e)-1:0] op_raw;

    // FETCH -> EXECUTE -> UPDATE, one step per clock
    always_comb
    begin
        case (state)
            ST_FETCH:   state_nxt = ST_EXECUTE;
            ST_EXECUTE: state_nxt = ST_UPDATE;
            ST_UPDATE:  state_nxt = ST_FETCH;
            default:    state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= ST_FETCH;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // zero after reset so the first decode is a nop
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ir <= '0;
        end
        else if (state == ST_FETCH)
        begin
            ir <= data;
        end
    end

    assign op_raw = ir[OPC_LSB +: $bits(alu_op_e)];

    // undefined codes fold into nop here so nothing downstream sees them
    always_comb
    begin
        if (op_raw <= OP_JMP)
            dec.op = alu_op_e'(op_raw);
        else
            dec.op = OP_NOP;
    end

    assign dec.src_a    = ir[SRCA_LSB +: `CPU_SEL_W];
    assign dec.src_b    = ir[SRCB_LSB +: `CPU_SEL_W];
    assign dec.dst      = ir[DST_LSB +: `CPU_SEL_W];
    assign dec.high_low = ir[HL_BIT];
    assign dec.imm      = ir[IMM_LSB +: `CPU_DATA_W/2];

    assign dec.in_fetch   = (state == ST_FETCH);
    assign dec.in_execute = (state == ST_EXECUTE);
    assign dec.in_update  = (state == ST_UPDATE);

    // reg_file and bus_ctrl both key their timing off these levels
    a_state_onehot: assert property (
        @(posedge clock) disable iff (!arst_n)
        $onehot({dec.in_fetch, dec.in_execute, dec.in_update})
    ) else $error("state levels not one-hot");

endmodule

// ==== cpu_if.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

// decoded instruction and state levels
interface decode_if;
    import cpu_pkg::*;

    alu_op_e                    op;
    logic [`CPU_SEL_W-1:0]      src_a;
    logic [`CPU_SEL_W-1:0]      src_b;
    logic [`CPU_SEL_W-1:0]      dst;
    logic [`CPU_DATA_W/2-1:0]   imm;
    logic                       high_low;
    logic                       in_fetch;
    logic                       in_execute;
    logic                       in_update;

    modport source (output op, src_a, src_b, dst, imm, high_low,
                    output in_fetch, in_execute, in_update);
    modport sink   (input op, src_a, src_b, dst, imm, high_low,
                    input in_fetch, in_execute, in_update);
endinterface

// register and flag values picked by src_a and src_b
interface operand_if;
    logic [`CPU_DATA_W-1:0] a_val;
    logic [`CPU_DATA_W-1:0] b_val;
    logic                   a_flag;
    logic                   b_flag;

    modport source (output a_val, b_val, a_flag, b_flag);
    modport sink   (input a_val, b_val, a_flag, b_flag);
endinterface

// what the current instruction produces
interface result_if;
    logic [`CPU_DATA_W-1:0] result;
    logic                   flag_out;
    logic                   write_en;
    logic                   store;
    logic                   access;
    logic                   take_branch;

    modport source (output result, flag_out, write_en, store, access, take_branch);
    modport sink   (input result, flag_out, write_en, store, access, take_branch);
endinterface

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // one instruction takes exactly one pass through these
    typedef enum logic [1:0] {
        ST_FETCH   = 2'd0,
        ST_EXECUTE = 2'd1,
        ST_UPDATE  = 2'd2
    } cpu_state_e;

    // codes above OP_JMP are undefined and run as OP_NOP
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LDI   = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_CMPEQ = 6'd9,
        OP_CMPLT = 6'd10,
        OP_BRF   = 6'd11,
        OP_JMP   = 6'd12
    } alu_op_e;

    // instruction word layout
    localparam int unsigned OPC_LSB  = 0;
    localparam int unsigned SRCA_LSB = 6;
    localparam int unsigned SRCB_LSB = 9;
    localparam int unsigned DST_LSB  = 12;
    localparam int unsigned HL_BIT   = 15;
    localparam int unsigned IMM_LSB  = 16;

endpackage

// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and address width
`define CPU_DATA_W 32

// general registers, each with its own flag
`define CPU_NREGS 8

// width of a register select field
`define CPU_SEL_W 3

// first instruction is fetched from here
`define CPU_RESET_PC 32'h0000_0000

`endif
